// ==== dv/ccl_golden.txt ====
# line 1 is the frame count; each frame is 8 rows of 16 pixels ('1' = 255, '0' = 0),
# a record count, records "label area xmin xmax ymin ymax" and the status word in hex
2
# frame 1: square, single pixels, a U with two arm labels, a 3x3 block
1100000100100100
1100000000100100
0000000000100100
0000000000111100
0001110000000000
0001110000000000
0001110000000000
1000000000000001
8
1 4 0 1 0 1
2 1 7 7 0 0
3 10 10 13 0 3
4 0 0 0 0 0
5 9 3 5 4 6
6 1 0 0 7 7
7 1 15 15 7 7
8 0 0 0 0 0
00000701
# frame 2: three arms joined by a bar, and a 3x4 block
0010010010000000
0010010010000000
0011111110000000
0000000000000000
0000000000001110
0000000000001110
0000000000001110
0000000000001110
7
1 13 2 8 0 2
2 0 0 0 0 0
3 0 0 0 0 0
4 12 12 14 4 7
5 0 0 0 0 0
6 0 0 0 0 0
7 0 0 0 0 0
00000401

// ==== dv/ccl_tb.sv ====
// testbench for the connected-component labeler, frames and expected results from a golden file
`timescale 1ns/1ps
`default_nettype none

module ccl_tb;
    import ccl_pkg::*;

    localparam int IMG_W   = 16;
    localparam int IMG_H   = 8;
    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst_fifo;
    logic        frame_vsync_i;
    logic        line_href_i;
    logic [7:0]  pixel_i;
    logic [11:0] s_axil_araddr_i;
    logic        s_axil_arvalid_i;
    logic        s_axil_arready_o;
    logic [31:0] s_axil_rdata_o;
    logic [1:0]  s_axil_rresp_o;
    logic        s_axil_rvalid_o;
    logic        s_axil_rready_i;

    int          cyc = 0;
    int          fd;
    bit          px [IMG_H][IMG_W];
    int          rec_cnt;
    int          rec [64][6];
    logic [31:0] exp_status;

    ccl_top #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) UUT (
        .clk              (clk),
        .rst_fifo         (rst_fifo),
        .frame_vsync_i    (frame_vsync_i),
        .line_href_i      (line_href_i),
        .pixel_i          (pixel_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%08h got 0x%08h",
                     $time, name, exp, got);
            $display("Checks failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Checks failed");
        $fatal(1, "run aborted");
    endtask

    // skips comment and blank lines
    task automatic next_line(output string s);
        int  rc;
        bit  found;
        found = 0;
        while (!found) begin
            rc = $fgets(s, fd);
            if (rc == 0) begin
                report_problem("golden file ended before all expected lines were read");
            end
            if (s.len() > 0 && s[0] != 8'h23 && s[0] != 8'h0a && s[0] != 8'h0d) begin
                found = 1;
            end
        end
    endtask

    // one AXI read, called and returning on a falling edge
    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int          start;
        int          delay;
        logic [31:0] first_data;
        logic [1:0]  first_resp;
        s_axil_araddr_i  = addr;
        s_axil_arvalid_i = 1'b1;
        start = cyc;
        while (!s_axil_arready_o && (cyc - start) < TIMEOUT) @(negedge clk);
        if (!s_axil_arready_o) begin
            report_problem("timed out waiting for arready on a read address");
        end
        @(negedge clk);
        s_axil_arvalid_i = 1'b0;
        start = cyc;
        while (!s_axil_rvalid_o && (cyc - start) < TIMEOUT) @(negedge clk);
        if (!s_axil_rvalid_o) begin
            report_problem("timed out waiting for rvalid after a read address");
        end
        first_data = s_axil_rdata_o;
        first_resp = s_axil_rresp_o;
        delay = int'($urandom % 4);
        // response must hold while rready stays low
        repeat (delay) begin
            @(negedge clk);
            check_value("s_axil_rvalid_o", 32'd1, 32'(s_axil_rvalid_o));
            check_value("s_axil_rdata_o", first_data, s_axil_rdata_o);
            check_value("s_axil_rresp_o", 32'(first_resp), 32'(s_axil_rresp_o));
        end
        s_axil_rready_i = 1'b1;
        @(negedge clk);
        s_axil_rready_i = 1'b0;
        // one handshake gives one response
        check_value("s_axil_rvalid_o", 32'd0, 32'(s_axil_rvalid_o));
        data = first_data;
        resp = first_resp;
    endtask

    task automatic check_reset_state();
        logic [31:0] d;
        logic [1:0]  r;
        check_value("s_axil_rvalid_o", 32'd0, 32'(s_axil_rvalid_o));
        check_value("s_axil_arready_o", 32'd1, 32'(s_axil_arready_o));
        read_reg(12'h000, d, r);
        check_value("s_axil_rresp_o (status)", 32'(RESP_OKAY), 32'(r));
        check_value("s_axil_rdata_o (status)", 32'd0, d);
    endtask

    task automatic load_frame();
        string s;
        int    rc;
        int    lbl, area, xmin, xmax, ymin, ymax;
        for (int y = 0; y < IMG_H; y++) begin
            next_line(s);
            if (s.len() < IMG_W) begin
                report_problem("pixel row in the golden file is shorter than the image width");
            end
            for (int x = 0; x < IMG_W; x++) begin
                px[y][x] = (s[x] == 8'h31);
            end
        end
        next_line(s);
        rc = $sscanf(s, "%d", rec_cnt);
        if (rc != 1 || rec_cnt > 63) begin
            report_problem("bad record count in the golden file");
        end
        for (int i = 0; i < rec_cnt; i++) begin
            next_line(s);
            rc = $sscanf(s, "%d %d %d %d %d %d", lbl, area, xmin, xmax, ymin, ymax);
            if (rc != 6) begin
                report_problem("record line in the golden file does not hold six numbers");
            end
            rec[i][0] = lbl;
            rec[i][1] = area;
            rec[i][2] = xmin;
            rec[i][3] = xmax;
            rec[i][4] = ymin;
            rec[i][5] = ymax;
        end
        next_line(s);
        rc = $sscanf(s, "%h", exp_status);
        if (rc != 1) begin
            report_problem("status line in the golden file is not a hex word");
        end
    endtask

    task automatic drive_frame();
        logic [31:0] d;
        logic [1:0]  r;
        frame_vsync_i = 1'b1;
        repeat (3) @(negedge clk);
        // frame open, so results are not ready
        read_reg(12'h000, d, r);
        check_value("s_axil_rdata_o[STATUS_READY_BIT]", 32'd0, 32'(d[STATUS_READY_BIT]));
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                line_href_i = 1'b1;
                pixel_i     = px[y][x] ? 8'd255 : 8'd0;
                @(negedge clk);
            end
            line_href_i = 1'b0;
            pixel_i     = 8'd0;
            repeat (2) @(negedge clk);
        end
        frame_vsync_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_ready();
        int          start;
        logic [31:0] d;
        logic [1:0]  r;
        start = cyc;
        read_reg(12'h000, d, r);
        while (!d[STATUS_READY_BIT] && (cyc - start) < TIMEOUT) begin
            read_reg(12'h000, d, r);
        end
        if (!d[STATUS_READY_BIT]) begin
            report_problem("timed out waiting for the ready bit in the status word");
        end
    endtask

    task automatic check_results();
        logic [31:0]  d;
        logic [1:0]   r;
        logic [11:0]  base;
        region_word_u w;
        read_reg(12'h000, d, r);
        check_value("s_axil_rresp_o (status)", 32'(RESP_OKAY), 32'(r));
        check_value("s_axil_rdata_o (status)", exp_status, d);
        for (int i = 0; i < rec_cnt; i++) begin
            base   = 12'(rec[i][0] * 8);
            w.area = 32'(rec[i][1]);
            read_reg(base, d, r);
            check_value($sformatf("s_axil_rresp_o (area, label %0d)", rec[i][0]),
                        32'(RESP_OKAY), 32'(r));
            check_value($sformatf("s_axil_rdata_o (area, label %0d)", rec[i][0]), w, d);
            w.box.xmin = coord_t'(rec[i][2]);
            w.box.xmax = coord_t'(rec[i][3]);
            w.box.ymin = coord_t'(rec[i][4]);
            w.box.ymax = coord_t'(rec[i][5]);
            read_reg(base + 12'd4, d, r);
            check_value($sformatf("s_axil_rresp_o (box, label %0d)", rec[i][0]),
                        32'(RESP_OKAY), 32'(r));
            check_value($sformatf("s_axil_rdata_o (box, label %0d)", rec[i][0]), w, d);
        end
    endtask

    task automatic check_bad_addresses();
        logic [11:0] bad [3];
        logic [31:0] d;
        logic [1:0]  r;
        // gap after status, unaligned inside label 1, label 64
        bad[0] = 12'h004;
        bad[1] = 12'h00A;
        bad[2] = 12'h200;
        for (int i = 0; i < 3; i++) begin
            read_reg(bad[i], d, r);
            check_value($sformatf("s_axil_rresp_o (address 0x%03h)", bad[i]),
                        32'(RESP_SLVERR), 32'(r));
            check_value($sformatf("s_axil_rdata_o (address 0x%03h)", bad[i]), 32'd0, d);
        end
    endtask

    initial begin
        string s;
        int    n_frames;
        int    rc;
        clk              = 1'b0;
        rst_fifo         = 1'b1;
        frame_vsync_i    = 1'b0;
        line_href_i      = 1'b0;
        pixel_i          = 8'd0;
        s_axil_araddr_i  = 12'h000;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i  = 1'b0;
        void'($urandom(32'h4df7));
        fd = $fopen("dv/ccl_golden.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open dv/ccl_golden.txt");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_fifo = 1'b0;
        @(negedge clk);
        check_reset_state();
        next_line(s);
        rc = $sscanf(s, "%d", n_frames);
        if (rc != 1) begin
            report_problem("golden file does not start with a frame count");
        end
        for (int f = 0; f < n_frames; f++) begin
            load_frame();
            drive_frame();
            wait_ready();
            check_results();
        end
        check_bad_addresses();
        $fclose(fd);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/ccl_pkg.sv
src/ccl_if.sv
src/ccl_label_decode.sv
src/ccl_union_execute.sv
src/ccl_region_result.sv
src/ccl_top.sv
dv/ccl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the labeler testbench with Verilator and runs it from the project root

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ccl_tb \
    -f project.f \
    -o ccl_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/ccl_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

// ==== src/ccl_if.sv ====
// pixel-update and merge buses between the labeler stages
`timescale 1ns/1ps
`default_nettype none

interface pix_upd_if;
    import ccl_pkg::*;

    logic   upd_valid;
    label_t upd_label;
    coord_t upd_x;
    coord_t upd_y;
    logic   upd_new;
    logic   upd_clear;

    modport source (output upd_valid, upd_label, upd_x, upd_y, upd_new, upd_clear);
    modport sink (input upd_valid, upd_label, upd_x, upd_y, upd_new, upd_clear);
endinterface

interface merge_if;
    import ccl_pkg::*;

    // src folds into dst, no ready since the sink takes one per cycle
    logic   fold_valid;
    label_t fold_src;
    label_t fold_dst;
    logic   resolve_done;

    modport source (output fold_valid, fold_src, fold_dst, resolve_done);
    modport sink (input fold_valid, fold_src, fold_dst, resolve_done);
endinterface

`default_nettype wire

// ==== src/ccl_label_decode.sv ====
// first pass: raster scan, provisional labels from left/above and union requests
`timescale 1ns/1ps
`default_nettype none

module ccl_label_decode #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic            clk,
    input  logic            rst_fifo,
    input  logic            frame_vsync_i,
    input  logic            line_href_i,
    input  logic [7:0]      pixel_i,
    pix_upd_if.source       upd,
    output logic            union_valid_o,
    output ccl_pkg::label_t union_a_o,
    output ccl_pkg::label_t union_b_o,
    output ccl_pkg::label_t label_count_o,
    output logic            frame_end_o,
    output logic            label_ovf_o
);
    import ccl_pkg::*;

    localparam label_t LAST_LABEL = label_t'(MAX_LABELS - 1);
    localparam int     XW         = (IMG_W > 1) ? $clog2(IMG_W) : 1;

    logic   vsync_q;
    coord_t x_q;
    coord_t y_q;
    label_t line_mem [IMG_W];
    label_t left_q;
    label_t cnt_q;
    label_t pair_a_q;
    label_t pair_b_q;
    logic   ovf_q;

    logic          pix_valid;
    logic          fg;
    logic          vs_rise;
    logic          alloc;
    logic          ovf_hit;
    logic          need_union;
    logic [XW-1:0] x_idx;
    label_t        left_lbl;
    label_t        above_lbl;
    label_t        lo_lbl;
    label_t        hi_lbl;
    label_t        cur_lbl;

    assign pix_valid = frame_vsync_i & line_href_i;
    assign fg        = pix_valid && (pixel_i == 8'd255);
    assign vs_rise   = frame_vsync_i & ~vsync_q;
    assign x_idx     = x_q[XW-1:0];

    // row 0 has nothing above, column 0 nothing to the left
    assign left_lbl  = (x_q == '0) ? '0 : left_q;
    assign above_lbl = (y_q == '0) ? '0 : line_mem[x_idx];
    assign lo_lbl    = (left_lbl < above_lbl) ? left_lbl : above_lbl;
    assign hi_lbl    = (left_lbl < above_lbl) ? above_lbl : left_lbl;

    always_comb begin
        alloc   = 1'b0;
        ovf_hit = 1'b0;
        if (!fg) begin
            cur_lbl = '0;
        end else if (hi_lbl == '0) begin
            // new component, table full means it stays background
            if (cnt_q == LAST_LABEL) begin
                cur_lbl = '0;
                ovf_hit = 1'b1;
            end else begin
                cur_lbl = cnt_q + label_t'(1);
                alloc   = 1'b1;
            end
        end else if (lo_lbl == '0) begin
            cur_lbl = hi_lbl;
        end else begin
            cur_lbl = lo_lbl;
        end
    end

    // skip repeats of the same pair along a shared edge
    assign need_union = fg && (lo_lbl != '0) && (lo_lbl != hi_lbl) &&
                        !((lo_lbl == pair_a_q) && (hi_lbl == pair_b_q));

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            vsync_q       <= 1'b0;
            x_q           <= '0;
            y_q           <= '0;
            left_q        <= '0;
            cnt_q         <= '0;
            pair_a_q      <= '0;
            pair_b_q      <= '0;
            ovf_q         <= 1'b0;
            upd.upd_valid <= 1'b0;
            upd.upd_new   <= 1'b0;
            upd.upd_clear <= 1'b0;
            union_valid_o <= 1'b0;
            frame_end_o   <= 1'b0;
        end else begin
            vsync_q       <= frame_vsync_i;
            upd.upd_clear <= vs_rise;
            frame_end_o   <= vsync_q & ~frame_vsync_i;
            upd.upd_valid <= fg && (cur_lbl != '0);
            upd.upd_new   <= alloc;
            union_valid_o <= need_union;
            if (vs_rise) begin
                x_q      <= '0;
                y_q      <= '0;
                left_q   <= '0;
                cnt_q    <= '0;
                pair_a_q <= '0;
                pair_b_q <= '0;
                ovf_q    <= 1'b0;
            end else if (pix_valid) begin
                left_q <= cur_lbl;
                if (x_q == coord_t'(IMG_W - 1)) begin
                    x_q <= '0;
                    if (y_q != coord_t'(IMG_H - 1)) begin
                        y_q <= y_q + coord_t'(1);
                    end
                end else begin
                    x_q <= x_q + coord_t'(1);
                end
                if (alloc) begin
                    cnt_q <= cur_lbl;
                end
                if (ovf_hit) begin
                    ovf_q <= 1'b1;
                end
                if (need_union) begin
                    pair_a_q <= lo_lbl;
                    pair_b_q <= hi_lbl;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        upd.upd_label <= cur_lbl;
        upd.upd_x     <= x_q;
        upd.upd_y     <= y_q;
        union_a_o     <= lo_lbl;
        union_b_o     <= hi_lbl;
        if (pix_valid) begin
            line_mem[x_idx] <= cur_lbl;
        end
    end

    assign label_count_o = cnt_q;
    assign label_ovf_o   = ovf_q;

    a_href_in_frame: assert property (@(posedge clk) disable iff (rst_fifo)
        $rose(line_href_i) |-> frame_vsync_i);

endmodule

`default_nettype wire

// ==== src/ccl_pkg.sv ====
// connected-component labeler shared types, status fields and response codes
`default_nettype none

package ccl_pkg;

    // label width sets the table size, label 0 is background
    localparam int LABEL_BITS = 6;
    localparam int MAX_LABELS = 1 << LABEL_BITS;

    typedef logic [LABEL_BITS-1:0] label_t;
    typedef logic [7:0] coord_t;

    typedef struct packed {
        coord_t xmin;
        coord_t xmax;
        coord_t ymin;
        coord_t ymax;
    } box_t;

    // one read word, area or box depending on address bit 2
    typedef union packed {
        logic [31:0] area;
        box_t        box;
    } region_word_u;

    // status word fields
    localparam int STATUS_READY_BIT = 0;
    localparam int STATUS_OVF_BIT   = 1;
    localparam int STATUS_COUNT_LSB = 8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== src/ccl_region_result.sv ====
// per-label area and box table with merge folding and an AXI4-Lite read port
`timescale 1ns/1ps
`default_nettype none

module ccl_region_result (
    input  logic            clk,
    input  logic            rst_fifo,
    pix_upd_if.sink         upd,
    merge_if.sink           mrg,
    input  logic            union_ovf_i,
    input  logic            label_ovf_i,
    input  ccl_pkg::label_t label_count_i,
    input  logic [11:0]     s_axil_araddr_i,
    input  logic            s_axil_arvalid_i,
    output logic            s_axil_arready_o,
    output logic [31:0]     s_axil_rdata_o,
    output logic [1:0]      s_axil_rresp_o,
    output logic            s_axil_rvalid_o,
    input  logic            s_axil_rready_i
);
    import ccl_pkg::*;

    logic [31:0]           area_mem [MAX_LABELS];
    box_t                  box_mem [MAX_LABELS];
    logic [MAX_LABELS-1:0] live_q;
    logic                  ready_q;
    logic                  ovf_q;

    box_t         pt_box;
    logic         ar_hs;
    logic         rd_hit;
    label_t       rd_lbl;
    region_word_u rd_word;
    logic [31:0]  status_word;

    function automatic box_t box_merge(input box_t a, input box_t b);
        box_t m;
        m.xmin = (a.xmin < b.xmin) ? a.xmin : b.xmin;
        m.xmax = (a.xmax > b.xmax) ? a.xmax : b.xmax;
        m.ymin = (a.ymin < b.ymin) ? a.ymin : b.ymin;
        m.ymax = (a.ymax > b.ymax) ? a.ymax : b.ymax;
        return m;
    endfunction

    assign pt_box = '{xmin: upd.upd_x, xmax: upd.upd_x, ymin: upd.upd_y, ymax: upd.upd_y};

    always_ff @(posedge clk) begin
        if (upd.upd_valid) begin
            if (upd.upd_new) begin
                area_mem[upd.upd_label] <= 32'd1;
                box_mem[upd.upd_label]  <= pt_box;
            end else begin
                area_mem[upd.upd_label] <= area_mem[upd.upd_label] + 32'd1;
                box_mem[upd.upd_label]  <= box_merge(box_mem[upd.upd_label], pt_box);
            end
        end else if (mrg.fold_valid) begin
            area_mem[mrg.fold_dst] <= area_mem[mrg.fold_dst] + area_mem[mrg.fold_src];
            box_mem[mrg.fold_dst]  <= box_merge(box_mem[mrg.fold_dst], box_mem[mrg.fold_src]);
        end
    end

    assign s_axil_arready_o = !s_axil_rvalid_o;
    assign ar_hs            = s_axil_arvalid_i && s_axil_arready_o;

    // live bit hides stale entries and folded-away labels
    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            live_q          <= '0;
            ready_q         <= 1'b0;
            ovf_q           <= 1'b0;
            s_axil_rvalid_o <= 1'b0;
        end else begin
            if (upd.upd_clear) begin
                live_q <= '0;
            end else if (upd.upd_valid && upd.upd_new) begin
                live_q[upd.upd_label] <= 1'b1;
            end else if (mrg.fold_valid) begin
                live_q[mrg.fold_src] <= 1'b0;
            end
            if (upd.upd_clear) begin
                ready_q <= 1'b0;
            end else if (mrg.resolve_done) begin
                ready_q <= 1'b1;
            end
            if (union_ovf_i || label_ovf_i) begin
                ovf_q <= 1'b1;
            end else if (upd.upd_clear) begin
                ovf_q <= 1'b0;
            end
            if (ar_hs) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    // 8k is the area word of label k, 8k+4 its box word
    assign rd_lbl = s_axil_araddr_i[3 +: LABEL_BITS];
    assign rd_hit = (s_axil_araddr_i[11:3+LABEL_BITS] == '0) && (rd_lbl != '0) &&
                    (s_axil_araddr_i[1:0] == 2'b00);

    always_comb begin
        rd_word.area = '0;
        if (s_axil_araddr_i[2]) begin
            rd_word.box = live_q[rd_lbl] ? box_mem[rd_lbl] : '0;
        end else begin
            rd_word.area = live_q[rd_lbl] ? area_mem[rd_lbl] : '0;
        end
    end

    always_comb begin
        status_word                                   = '0;
        status_word[STATUS_READY_BIT]                 = ready_q;
        status_word[STATUS_OVF_BIT]                   = ovf_q;
        status_word[STATUS_COUNT_LSB +: LABEL_BITS]   = label_count_i;
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            if (s_axil_araddr_i == '0) begin
                s_axil_rdata_o <= status_word;
                s_axil_rresp_o <= RESP_OKAY;
            end else if (rd_hit) begin
                s_axil_rdata_o <= rd_word;
                s_axil_rresp_o <= RESP_OKAY;
            end else begin
                s_axil_rdata_o <= '0;
                s_axil_rresp_o <= RESP_SLVERR;
            end
        end
    end

    a_rdata_hold: assert property (@(posedge clk) disable iff (rst_fifo)
        s_axil_rvalid_o && !s_axil_rready_i |=>
        $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o));

    // sweep must finish before the next frame's pixels arrive
    a_fold_vs_pixel: assert property (@(posedge clk) disable iff (rst_fifo)
        !(mrg.fold_valid && upd.upd_valid));

endmodule

`default_nettype wire

// ==== src/ccl_top.sv ====
// streaming connected-component labeler top level with AXI4-Lite readout
`timescale 1ns/1ps
`default_nettype none

module ccl_top #(
    parameter int IMG_W       = 256,
    parameter int IMG_H       = 256,
    parameter int UNION_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst_fifo,
    input  logic        frame_vsync_i,
    input  logic        line_href_i,
    input  logic [7:0]  pixel_i,
    input  logic [11:0] s_axil_araddr_i,
    input  logic        s_axil_arvalid_i,
    output logic        s_axil_arready_o,
    output logic [31:0] s_axil_rdata_o,
    output logic [1:0]  s_axil_rresp_o,
    output logic        s_axil_rvalid_o,
    input  logic        s_axil_rready_i
);
    import ccl_pkg::*;

    pix_upd_if upd_bus ();
    merge_if   mrg_bus ();

    logic   union_valid;
    label_t union_a;
    label_t union_b;
    label_t label_count;
    logic   frame_end;
    logic   label_ovf;
    logic   union_ovf;

    ccl_label_decode #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_decode (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .frame_vsync_i (frame_vsync_i),
        .line_href_i   (line_href_i),
        .pixel_i       (pixel_i),
        .upd           (upd_bus.source),
        .union_valid_o (union_valid),
        .union_a_o     (union_a),
        .union_b_o     (union_b),
        .label_count_o (label_count),
        .frame_end_o   (frame_end),
        .label_ovf_o   (label_ovf)
    );

    ccl_union_execute #(
        .UNION_DEPTH (UNION_DEPTH)
    ) u_execute (
        .clk           (clk),
        .rst_fifo      (rst_fifo),
        .union_valid_i (union_valid),
        .union_a_i     (union_a),
        .union_b_i     (union_b),
        .label_count_i (label_count),
        .frame_end_i   (frame_end),
        .mrg           (mrg_bus.source),
        .union_ovf_o   (union_ovf)
    );

    ccl_region_result u_result (
        .clk              (clk),
        .rst_fifo         (rst_fifo),
        .upd              (upd_bus.sink),
        .mrg              (mrg_bus.sink),
        .union_ovf_i      (union_ovf),
        .label_ovf_i      (label_ovf),
        .label_count_i    (label_count),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i)
    );

endmodule

`default_nettype wire

// ==== src/ccl_union_execute.sv ====
// union queue and parent table, find/link engine and end-of-frame resolve sweep
`timescale 1ns/1ps
`default_nettype none

module ccl_union_execute #(
    parameter int UNION_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst_fifo,
    input  logic            union_valid_i,
    input  ccl_pkg::label_t union_a_i,
    input  ccl_pkg::label_t union_b_i,
    input  ccl_pkg::label_t label_count_i,
    input  logic            frame_end_i,
    merge_if.source         mrg,
    output logic            union_ovf_o
);
    import ccl_pkg::*;

    localparam int PTR_W = (UNION_DEPTH > 1) ? $clog2(UNION_DEPTH) : 1;
    localparam int CNT_W = $clog2(UNION_DEPTH + 1);
    localparam label_t LAST_LABEL = label_t'(MAX_LABELS - 1);

    typedef enum logic [2:0] {
        S_CLEAR, S_IDLE, S_FIND_A, S_FIND_B, S_SWEEP, S_DONE
    } state_t;

    state_t           state_q;
    label_t           parent [MAX_LABELS];
    label_t           q_a [UNION_DEPTH];
    label_t           q_b [UNION_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] q_cnt_q;
    label_t           walk_q;
    label_t           root_a_q;
    label_t           req_b_q;
    label_t           sweep_q;
    label_t           clr_q;
    logic             end_pend_q;

    logic   q_full;
    logic   push;
    logic   pop;
    logic   at_root;
    logic   link_we;
    label_t link_child;
    label_t link_par;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(UNION_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign q_full  = (q_cnt_q == CNT_W'(UNION_DEPTH));
    assign push    = union_valid_i && !q_full;
    assign pop     = (state_q == S_IDLE) && (q_cnt_q != '0);
    assign at_root = (parent[walk_q] == walk_q);

    // larger root goes under the smaller, so a root is its set's minimum
    assign link_we    = (state_q == S_FIND_B) && at_root && (walk_q != root_a_q);
    assign link_child = (walk_q > root_a_q) ? walk_q : root_a_q;
    assign link_par   = (walk_q > root_a_q) ? root_a_q : walk_q;

    always_ff @(posedge clk) begin
        if (push) begin
            q_a[wr_ptr_q] <= union_a_i;
            q_b[wr_ptr_q] <= union_b_i;
        end
        if (state_q == S_CLEAR) begin
            parent[clr_q] <= clr_q;
        end else if (link_we) begin
            parent[link_child] <= link_par;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_fifo) begin
            state_q          <= S_CLEAR;
            clr_q            <= '0;
            wr_ptr_q         <= '0;
            rd_ptr_q         <= '0;
            q_cnt_q          <= '0;
            walk_q           <= '0;
            root_a_q         <= '0;
            req_b_q          <= '0;
            sweep_q          <= '0;
            end_pend_q       <= 1'b0;
            union_ovf_o      <= 1'b0;
            mrg.fold_valid   <= 1'b0;
            mrg.fold_src     <= '0;
            mrg.fold_dst     <= '0;
            mrg.resolve_done <= 1'b0;
        end else begin
            union_ovf_o      <= union_valid_i && q_full;
            mrg.fold_valid   <= 1'b0;
            mrg.resolve_done <= 1'b0;
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (push && !pop) begin
                q_cnt_q <= q_cnt_q + CNT_W'(1);
            end else if (pop && !push) begin
                q_cnt_q <= q_cnt_q - CNT_W'(1);
            end
            if (frame_end_i) begin
                end_pend_q <= 1'b1;
            end
            case (state_q)
                S_CLEAR: begin
                    // identity table, one entry per cycle
                    clr_q <= clr_q + label_t'(1);
                    if (clr_q == LAST_LABEL) begin
                        state_q <= S_IDLE;
                    end
                end
                S_IDLE: begin
                    if (pop) begin
                        walk_q  <= q_a[rd_ptr_q];
                        req_b_q <= q_b[rd_ptr_q];
                        state_q <= S_FIND_A;
                    end else if (end_pend_q) begin
                        end_pend_q <= 1'b0;
                        sweep_q    <= label_t'(1);
                        walk_q     <= label_t'(1);
                        state_q    <= (label_count_i == '0) ? S_DONE : S_SWEEP;
                    end
                end
                S_FIND_A: begin
                    if (at_root) begin
                        root_a_q <= walk_q;
                        walk_q   <= req_b_q;
                        state_q  <= S_FIND_B;
                    end else begin
                        walk_q <= parent[walk_q];
                    end
                end
                S_FIND_B: begin
                    if (at_root) begin
                        state_q <= S_IDLE;
                    end else begin
                        walk_q <= parent[walk_q];
                    end
                end
                S_SWEEP: begin
                    if (at_root) begin
                        mrg.fold_valid <= (walk_q != sweep_q);
                        mrg.fold_src   <= sweep_q;
                        mrg.fold_dst   <= walk_q;
                        if (sweep_q == label_count_i) begin
                            state_q <= S_DONE;
                        end else begin
                            sweep_q <= sweep_q + label_t'(1);
                            walk_q  <= sweep_q + label_t'(1);
                        end
                    end else begin
                        walk_q <= parent[walk_q];
                    end
                end
                S_DONE: begin
                    // table is rebuilt ahead of the next frame
                    mrg.resolve_done <= 1'b1;
                    clr_q            <= '0;
                    state_q          <= S_CLEAR;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // every entry met on a find or sweep walk points at a smaller or equal label
    a_parent_smaller: assert property (@(posedge clk) disable iff (rst_fifo)
        (state_q != S_CLEAR) |-> (parent[walk_q] <= walk_q));

endmodule

`default_nettype wire
